// File: cache_wh.f
hdl/cache_wh_pkg.sv
hdl/two_entry_fifo.sv
hdl/dma_wormhole_bridge.sv
hdl/wh_mem_endpoint.sv
hdl/cache_wh_top.sv
tb/cache_wh_tb.sv

// File: tb/cache_wh_tb.sv
/*
 * Directed testbench for the cache DMA to wormhole loop.
 * Acts as the cache, keeps a reference word array,
 * checks fill data and handshakes, with a cycle watchdog.
 */

`timescale 1ns/1ns

module cache_wh_tb;

  import cache_wh_pkg::*;

  // about 40 operations at up to 60 cycles each under stalls
  localparam int max_cycles = 3000;

  logic                  clk_i;
  logic                  reset_i;
  dma_pkt_t              dma_pkt_i;
  logic                  dma_pkt_v_i;
  logic                  dma_pkt_yumi_o;
  flit_t                 dma_data_i;
  logic                  dma_data_v_i;
  logic                  dma_data_yumi_o;
  flit_t                 dma_data_o;
  logic                  dma_data_v_o;
  logic                  dma_data_ready_i;
  logic [cord_width-1:0] my_cord_i;
  logic [cord_width-1:0] dest_cord_i;
  logic [cid_width-1:0]  my_cid_i;

  flit_t       ref_mem [mem_words];
  logic [31:0] lcg_state = 32'h472e4df8;
  int          flit_errors = 0;
  int          flag_errors = 0;
  int          cycle_count = 0;
  string       current_task = "reset";

  cache_wh_top uut (.*);

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count == max_cycles) begin
      $display("timeout after %0d cycles, %s never finished", max_cycles, current_task);
      $display("errors: flit=%0d flag=%0d", flit_errors, flag_errors);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // block-aligned word index, as the endpoint maps byte addresses
  function automatic int word_base(input logic [31:0] addr);
    return ((addr >> 2) % mem_words) / block_words * block_words;
  endfunction

  task automatic check_flit(input flit_t got, input flit_t exp, input string what);
    if (got !== exp) begin
      flit_errors++;
      $display("ERR @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      flag_errors++;
      $display("ERR @%0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // every task starts and ends just after a falling edge
  task automatic send_pkt(input logic write_not_read, input logic [31:0] addr);
    dma_pkt_t pkt;
    pkt.write_not_read = write_not_read;
    pkt.addr           = addr;
    dma_pkt_i          = pkt;
    dma_pkt_v_i        = 1'b1;
    #5;
    while (!dma_pkt_yumi_o) begin
      @(negedge clk_i);
      #5;
    end
    @(negedge clk_i);
    dma_pkt_v_i = 1'b0;
  endtask

  task automatic feed_block(input logic [31:0] addr, input bit gaps);
    int          base;
    int          k;
    logic [31:0] r;
    base = word_base(addr);
    for (k = 0; k < block_words; k++)
      ref_mem[base + k] = next_random();
    k = 0;
    while (k < block_words) begin
      r            = next_random();
      dma_data_v_i = !(gaps && r[1:0] == 2'b00);
      dma_data_i   = dma_data_v_i ? ref_mem[base + k] : r;
      #5;
      if (dma_data_v_i && dma_data_yumi_o)
        k++;
      else if (!dma_data_v_i)
        check_flag(dma_data_yumi_o, 1'b0, "evict yumi without valid");
      @(negedge clk_i);
    end
    dma_data_v_i = 1'b0;
  endtask

  task automatic write_block(input logic [31:0] addr, input bit gaps);
    send_pkt(1'b1, addr);
    feed_block(addr, gaps);
  endtask

  task automatic read_block(input logic [31:0] addr, input bit stalls);
    int          base;
    int          got;
    logic [31:0] r;
    base = word_base(addr);
    got  = 0;
    send_pkt(1'b0, addr);
    while (got < block_words) begin
      r                = next_random();
      dma_data_ready_i = stalls ? (r[2:1] != 2'b00) : 1'b1;
      #5;
      if (dma_data_v_o && dma_data_ready_i) begin
        check_flit(dma_data_o, ref_mem[base + got], $sformatf("fill word %0d", got));
        got++;
      end
      @(negedge clk_i);
    end
    dma_data_ready_i = 1'b1;
    // a fifth word would show up here
    repeat (6) begin
      #5;
      check_flag(dma_data_v_o, 1'b0, "fill valid after last word");
      @(negedge clk_i);
    end
  endtask

  task automatic idle_after_reset();
    current_task = "idle_after_reset";
    repeat (8) begin
      #5;
      check_flag(dma_pkt_yumi_o, 1'b0, "pkt yumi while idle");
      check_flag(dma_data_yumi_o, 1'b0, "evict yumi while idle");
      check_flag(dma_data_v_o, 1'b0, "fill valid while idle");
      @(negedge clk_i);
    end
  endtask

  task automatic write_then_read();
    current_task = "write_then_read";
    write_block(32'h0000_0100, 1'b0);
    read_block(32'h0000_0100, 1'b0);
  endtask

  task automatic queued_writes();
    current_task = "queued_writes";
    send_pkt(1'b1, 32'h0000_0240);
    send_pkt(1'b1, 32'h0000_0380);
    feed_block(32'h0000_0240, 1'b0);
    feed_block(32'h0000_0380, 1'b0);
    // no write pending, so a spare word must stay unconsumed
    dma_data_i   = next_random();
    dma_data_v_i = 1'b1;
    repeat (5) begin
      #5;
      check_flag(dma_data_yumi_o, 1'b0, "evict yumi beyond block");
      @(negedge clk_i);
    end
    dma_data_v_i = 1'b0;
    read_block(32'h0000_0240, 1'b0);
    read_block(32'h0000_0380, 1'b0);
  endtask

  task automatic read_with_stalls();
    current_task = "read_with_stalls";
    read_block(32'h0000_0100, 1'b1);
    read_block(32'h0000_0380, 1'b1);
  endtask

  task automatic write_with_gaps();
    current_task = "write_with_gaps";
    write_block(32'h0000_0050, 1'b1);
    read_block(32'h0000_0050, 1'b1);
  endtask

  task automatic overwrite_block();
    current_task = "overwrite_block";
    write_block(32'h0000_0240, 1'b1);
    read_block(32'h0000_0240, 1'b0);
  endtask

  initial begin
    clk_i            = 1'b0;
    reset_i          = 1'b1;
    dma_pkt_i        = '0;
    dma_pkt_v_i      = 1'b0;
    dma_data_i       = '0;
    dma_data_v_i     = 1'b0;
    dma_data_ready_i = 1'b1;
    my_cord_i        = 4'h1;
    dest_cord_i      = 4'h3;
    my_cid_i         = 2'h2;
    repeat (4) @(negedge clk_i);
    reset_i = 1'b0;

    idle_after_reset();
    write_then_read();
    queued_writes();
    read_with_stalls();
    write_with_gaps();
    overwrite_block();

    $display("errors: flit=%0d flag=%0d", flit_errors, flag_errors);
    if (flit_errors + flag_errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: hdl/cache_wh_top.sv
/*
 * Closed-loop top: packet FIFO, bridge,
 * request and response link FIFOs, memory endpoint.
 */

`timescale 1ns/1ns

module cache_wh_top (
  input  logic                                clk_i,
  input  logic                                reset_i,

  input  cache_wh_pkg::dma_pkt_t              dma_pkt_i,
  input  logic                                dma_pkt_v_i,
  output logic                                dma_pkt_yumi_o,

  input  cache_wh_pkg::flit_t                 dma_data_i,
  input  logic                                dma_data_v_i,
  output logic                                dma_data_yumi_o,

  output cache_wh_pkg::flit_t                 dma_data_o,
  output logic                                dma_data_v_o,
  input  logic                                dma_data_ready_i,

  input  logic [cache_wh_pkg::cord_width-1:0] my_cord_i,
  input  logic [cache_wh_pkg::cord_width-1:0] dest_cord_i,
  input  logic [cache_wh_pkg::cid_width-1:0]  my_cid_i
);

  import cache_wh_pkg::*;

  dma_pkt_t pkt_head;
  logic     pkt_ready, pkt_head_v, pkt_pop;
  flit_t    req_flit, req_head;
  logic     req_v, req_ready, req_head_v, req_head_ready;
  flit_t    rsp_flit, rsp_head;
  logic     rsp_v, rsp_ready, rsp_head_v, rsp_head_ready;

  // taken whenever there is room
  assign dma_pkt_yumi_o = pkt_ready & dma_pkt_v_i;

  two_entry_fifo #(.payload_t(dma_pkt_t)) pkt_fifo (
    .clk_i(clk_i), .reset_i(reset_i),
    .data_i(dma_pkt_i), .v_i(dma_pkt_v_i), .ready_o(pkt_ready),
    .data_o(pkt_head), .v_o(pkt_head_v), .ready_i(pkt_pop)
  );

  dma_wormhole_bridge bridge (
    .clk_i(clk_i), .reset_i(reset_i),
    .dma_pkt_i(pkt_head), .dma_pkt_v_i(pkt_head_v), .dma_pkt_yumi_o(pkt_pop),
    .dma_data_i(dma_data_i), .dma_data_v_i(dma_data_v_i), .dma_data_yumi_o(dma_data_yumi_o),
    .dma_data_o(dma_data_o), .dma_data_v_o(dma_data_v_o), .dma_data_ready_i(dma_data_ready_i),
    .req_flit_o(req_flit), .req_v_o(req_v), .req_ready_i(req_ready),
    .rsp_flit_i(rsp_head), .rsp_v_i(rsp_head_v), .rsp_ready_o(rsp_head_ready),
    .my_cord_i(my_cord_i), .dest_cord_i(dest_cord_i), .my_cid_i(my_cid_i)
  );

  two_entry_fifo #(.payload_t(flit_t)) req_fifo (
    .clk_i(clk_i), .reset_i(reset_i),
    .data_i(req_flit), .v_i(req_v), .ready_o(req_ready),
    .data_o(req_head), .v_o(req_head_v), .ready_i(req_head_ready)
  );

  wh_mem_endpoint endpoint (
    .clk_i(clk_i), .reset_i(reset_i),
    .flit_i(req_head), .flit_v_i(req_head_v), .flit_ready_o(req_head_ready),
    .rsp_flit_o(rsp_flit), .rsp_v_o(rsp_v), .rsp_ready_i(rsp_ready)
  );

  two_entry_fifo #(.payload_t(flit_t)) rsp_fifo (
    .clk_i(clk_i), .reset_i(reset_i),
    .data_i(rsp_flit), .v_i(rsp_v), .ready_o(rsp_ready),
    .data_o(rsp_head), .v_o(rsp_head_v), .ready_i(rsp_head_ready)
  );

endmodule

// File: hdl/wh_mem_endpoint.sv
/*
 * Wormhole memory endpoint.
 * Parses request flits, stores write blocks in a word array
 * and answers reads with a reply header plus the block words.
 */

`timescale 1ns/1ns

module wh_mem_endpoint (
  input  logic                clk_i,
  input  logic                reset_i,

  input  cache_wh_pkg::flit_t flit_i,
  input  logic                flit_v_i,
  output logic                flit_ready_o,

  output cache_wh_pkg::flit_t rsp_flit_o,
  output logic                rsp_v_o,
  input  logic                rsp_ready_i
);

  import cache_wh_pkg::*;

  typedef logic [$clog2(mem_words)-1:0] word_idx_t;

  typedef enum logic [2:0] {
    EP_HEADER,
    EP_ADDR,
    EP_DATA,
    EP_REPLY_HEADER,
    EP_REPLY_DATA
  } ep_state_e;

  ep_state_e              state_r;
  wh_header_t             hdr_in;
  wh_header_t             req_hdr_r;
  wh_header_t             reply_hdr;
  word_idx_t              base_r;
  word_idx_t              word_idx;
  logic [count_width-1:0] count_r;
  logic                   flit_xfer;
  logic                   rsp_xfer;
  logic                   last_word;
  flit_t                  mem_r [mem_words];

  assign hdr_in    = flit_i;
  assign word_idx  = base_r + word_idx_t'(count_r);
  assign last_word = (count_r == count_width'(block_words - 1));

  assign flit_ready_o = (state_r == EP_HEADER) || (state_r == EP_ADDR) || (state_r == EP_DATA);
  assign flit_xfer    = flit_v_i & flit_ready_o;
  assign rsp_v_o      = (state_r == EP_REPLY_HEADER) || (state_r == EP_REPLY_DATA);
  assign rsp_xfer     = rsp_v_o & rsp_ready_i;

  // reply goes back to the requester, same cid
  assign reply_hdr.unused         = '0;
  assign reply_hdr.write_not_read = 1'b0;
  assign reply_hdr.len            = len_width'(block_words);
  assign reply_hdr.cid            = req_hdr_r.cid;
  assign reply_hdr.src_cord       = req_hdr_r.dest_cord;
  assign reply_hdr.dest_cord      = req_hdr_r.src_cord;

  assign rsp_flit_o = (state_r == EP_REPLY_HEADER) ? flit_t'(reply_hdr) : mem_r[word_idx];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= EP_HEADER;
      count_r <= '0;
    end else begin
      case (state_r)
        EP_HEADER: begin
          if (flit_xfer)
            state_r <= EP_ADDR;
        end
        EP_ADDR: begin
          if (flit_xfer) begin
            count_r <= '0;
            state_r <= req_hdr_r.write_not_read ? EP_DATA : EP_REPLY_HEADER;
          end
        end
        EP_DATA: begin
          if (flit_xfer) begin
            count_r <= count_r + 1'b1;
            if (last_word)
              state_r <= EP_HEADER;
          end
        end
        EP_REPLY_HEADER: begin
          if (rsp_xfer)
            state_r <= EP_REPLY_DATA;
        end
        EP_REPLY_DATA: begin
          if (rsp_xfer) begin
            count_r <= count_r + 1'b1;
            if (last_word)
              state_r <= EP_HEADER;
          end
        end
        default: state_r <= EP_HEADER;
      endcase
    end
  end

  // header fields and block base, plus the array itself
  always_ff @(posedge clk_i) begin
    if (state_r == EP_HEADER && flit_xfer)
      req_hdr_r <= hdr_in;
    // byte address to word index, aligned to the block
    if (state_r == EP_ADDR && flit_xfer)
      base_r <= flit_i[2 +: $bits(word_idx_t)] & ~word_idx_t'(block_words - 1);
    if (state_r == EP_DATA && flit_xfer)
      mem_r[word_idx] <= flit_i;
  end

  a_len_rule: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_r == EP_HEADER && flit_xfer)
      |-> hdr_in.len == (hdr_in.write_not_read ? len_width'(1 + block_words)
                                               : len_width'(1)));

endmodule

// File: hdl/dma_wormhole_bridge.sv
/*
 * Cache DMA to wormhole bridge control.
 * Send FSM turns DMA packets and evict data into request flits.
 * Receive FSM drops the reply header and forwards fill flits.
 */

`timescale 1ns/1ns

module dma_wormhole_bridge (
  input  logic                             clk_i,
  input  logic                             reset_i,

  input  cache_wh_pkg::dma_pkt_t           dma_pkt_i,
  input  logic                             dma_pkt_v_i,
  output logic                             dma_pkt_yumi_o,

  input  cache_wh_pkg::flit_t              dma_data_i,
  input  logic                             dma_data_v_i,
  output logic                             dma_data_yumi_o,

  output cache_wh_pkg::flit_t              dma_data_o,
  output logic                             dma_data_v_o,
  input  logic                             dma_data_ready_i,

  output cache_wh_pkg::flit_t              req_flit_o,
  output logic                             req_v_o,
  input  logic                             req_ready_i,

  input  cache_wh_pkg::flit_t              rsp_flit_i,
  input  logic                             rsp_v_i,
  output logic                             rsp_ready_o,

  input  logic [cache_wh_pkg::cord_width-1:0] my_cord_i,
  input  logic [cache_wh_pkg::cord_width-1:0] dest_cord_i,
  input  logic [cache_wh_pkg::cid_width-1:0]  my_cid_i
);

  import cache_wh_pkg::*;

  typedef enum logic [1:0] {
    SEND_RESET,
    SEND_HEADER,
    SEND_ADDR,
    SEND_DATA
  } send_state_e;

  typedef enum logic [1:0] {
    RECV_RESET,
    RECV_HEADER,
    RECV_DATA
  } recv_state_e;

  send_state_e            send_state_r, send_state_n;
  recv_state_e            recv_state_r, recv_state_n;
  logic [count_width-1:0] send_count_r, send_count_n;
  logic [count_width-1:0] recv_count_r, recv_count_n;
  wh_header_t             header;
  logic                   fill_xfer;

  assign header.unused         = '0;
  assign header.write_not_read = dma_pkt_i.write_not_read;
  // header + addr + data, or header + addr
  assign header.len            = dma_pkt_i.write_not_read ? len_width'(1 + block_words)
                                                          : len_width'(1);
  assign header.cid            = my_cid_i;
  assign header.src_cord       = my_cord_i;
  assign header.dest_cord      = dest_cord_i;

  always_comb begin
    send_state_n    = send_state_r;
    send_count_n    = send_count_r;
    req_v_o         = 1'b0;
    req_flit_o      = dma_data_i;
    dma_pkt_yumi_o  = 1'b0;
    dma_data_yumi_o = 1'b0;
    case (send_state_r)
      SEND_RESET: begin
        send_state_n = SEND_HEADER;
      end
      SEND_HEADER: begin
        req_flit_o = header;
        req_v_o    = dma_pkt_v_i;
        if (dma_pkt_v_i && req_ready_i)
          send_state_n = SEND_ADDR;
      end
      SEND_ADDR: begin
        req_flit_o = dma_pkt_i.addr;
        req_v_o    = dma_pkt_v_i;
        if (dma_pkt_v_i && req_ready_i) begin
          dma_pkt_yumi_o = 1'b1;
          send_state_n   = dma_pkt_i.write_not_read ? SEND_DATA : SEND_HEADER;
        end
      end
      SEND_DATA: begin
        req_v_o = dma_data_v_i;
        if (dma_data_v_i && req_ready_i) begin
          dma_data_yumi_o = 1'b1;
          if (send_count_r == count_width'(block_words - 1)) begin
            send_count_n = '0;
            send_state_n = SEND_HEADER;
          end else begin
            send_count_n = send_count_r + 1'b1;
          end
        end
      end
      default: begin
        send_state_n = SEND_HEADER;
      end
    endcase
  end

  // fill data goes straight through to the cache
  assign dma_data_o = rsp_flit_i;
  assign fill_xfer  = (recv_state_r == RECV_DATA) & rsp_v_i & dma_data_ready_i;

  always_comb begin
    recv_state_n = recv_state_r;
    recv_count_n = recv_count_r;
    rsp_ready_o  = 1'b0;
    dma_data_v_o = 1'b0;
    case (recv_state_r)
      RECV_RESET: begin
        recv_state_n = RECV_HEADER;
      end
      RECV_HEADER: begin
        rsp_ready_o = 1'b1;
        if (rsp_v_i)
          recv_state_n = RECV_DATA;
      end
      RECV_DATA: begin
        rsp_ready_o  = dma_data_ready_i;
        dma_data_v_o = rsp_v_i;
        if (fill_xfer) begin
          if (recv_count_r == count_width'(block_words - 1)) begin
            recv_count_n = '0;
            recv_state_n = RECV_HEADER;
          end else begin
            recv_count_n = recv_count_r + 1'b1;
          end
        end
      end
      default: begin
        recv_state_n = RECV_HEADER;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      send_state_r <= SEND_RESET;
      recv_state_r <= RECV_RESET;
      send_count_r <= '0;
      recv_count_r <= '0;
    end else begin
      send_state_r <= send_state_n;
      recv_state_r <= recv_state_n;
      send_count_r <= send_count_n;
      recv_count_r <= recv_count_n;
    end
  end

  a_yumi_needs_data: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_data_yumi_o |-> dma_data_v_i && send_state_r == SEND_DATA);

  // fill count only runs inside a reply, so each block starts at word 0
  a_fill_count_idle: assert property (@(posedge clk_i) disable iff (reset_i)
    recv_state_r != RECV_DATA |-> recv_count_r == '0);

endmodule

// File: hdl/two_entry_fifo.sv
/*
 * Two-slot valid/ready FIFO.
 * Payload type is a parameter so one module carries
 * DMA packets as well as link flits.
 */

`timescale 1ns/1ns

module two_entry_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     reset_i,

  input  payload_t data_i,
  input  logic     v_i,
  output logic     ready_o,

  output payload_t data_o,
  output logic     v_o,
  input  logic     ready_i
);

  payload_t   mem_r [2];
  logic       rd_ptr_r;
  logic       wr_ptr_r;
  logic [1:0] count_r;
  logic       push;
  logic       pop;

  assign ready_o = (count_r != 2'd2);
  assign v_o     = (count_r != 2'd0);
  assign data_o  = mem_r[rd_ptr_r];

  assign push = v_i & ready_o;
  assign pop  = v_o & ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_r <= 1'b0;
      wr_ptr_r <= 1'b0;
      count_r  <= 2'd0;
    end else begin
      if (push)
        wr_ptr_r <= ~wr_ptr_r;
      if (pop)
        rd_ptr_r <= ~rd_ptr_r;
      count_r <= count_r + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk_i) begin
    if (push)
      mem_r[wr_ptr_r] <= data_i;
  end

  // occupancy and pointer distance agree, so an empty FIFO never pops a stale slot
  a_count_matches_ptrs: assert property (@(posedge clk_i) disable iff (reset_i)
    count_r != 2'd3 && count_r[0] == (rd_ptr_r ^ wr_ptr_r));

endmodule

// File: hdl/cache_wh_pkg.sv
/*
 * Shared definitions for the cache DMA to wormhole bridge.
 * Link and DMA widths, block length, counter width,
 * DMA packet struct, flit type and wormhole header flit struct.
 */

package cache_wh_pkg;

  localparam int addr_width  = 32;
  // flit must match the DMA data width
  localparam int flit_width  = 32;
  localparam int block_words = 4;
  localparam int count_width = 2;

  localparam int cord_width  = 4;
  localparam int cid_width   = 2;
  localparam int len_width   = 4;

  // endpoint word array depth
  localparam int mem_words   = 256;

  typedef logic [flit_width-1:0] flit_t;

  typedef struct packed {
    logic                  write_not_read;
    logic [addr_width-1:0] addr;
  } dma_pkt_t;

  // fills exactly one flit, dest_cord in the low bits
  typedef struct packed {
    logic [flit_width-len_width-cid_width-2*cord_width-2:0] unused;
    logic                  write_not_read;
    logic [len_width-1:0]  len;
    logic [cid_width-1:0]  cid;
    logic [cord_width-1:0] src_cord;
    logic [cord_width-1:0] dest_cord;
  } wh_header_t;

endpackage
